/* common/axi_pkg.sv */
// ------------------
// AXI bus encodings and widths
// Control-word and FIFO word layouts
// ------------------
package axi_pkg;

	localparam int addr_w = 16;
	localparam int id_w   = 4;
	// Beats minus one
	localparam int len_w  = 4;

	// Burst types
	localparam logic [1:0] burst_fixed = 2'd0;
	localparam logic [1:0] burst_incr  = 2'd1;
	localparam logic [1:0] burst_wrap  = 2'd2;

	// Response codes
	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	// ------------------
	// Control word fields
	// ------------------
	localparam int cntl_w    = 30;
	localparam int addr_lsb  = 0;
	localparam int addr_msb  = 15;
	localparam int len_lsb   = 16;
	localparam int len_msb   = 19;
	localparam int size_lsb  = 20;
	localparam int size_msb  = 22;
	localparam int burst_lsb = 23;
	localparam int burst_msb = 24;
	localparam int id_lsb    = 25;
	localparam int id_msb    = 28;
	localparam int err_bit   = 29;

	// W word is {id, last, strb, data}, R word is {last, id, resp, data}
	localparam int wdat_w = 41;
	localparam int rdat_w = 39;

endpackage

/* common/mem_pkg.sv */
// ------------------
// SRAM geometry, FIFO depths
// and controller state codes
// ------------------
package mem_pkg;

	localparam int data_w     = 32;
	localparam int strb_w     = 4;
	localparam int mem_addr_w = 14;
	localparam int mem_words  = 16384;

	localparam int cntl_fifo_depth = 4;
	localparam int data_fifo_depth = 16;

	// Controller FSM
	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_first = 2'd1;
	localparam logic [1:0] st_burst = 2'd2;

endpackage

/* files.f */
common/axi_pkg.sv
common/mem_pkg.sv
source/sync_fifo.sv
source/axi_front.sv
mem_cntl/arbiter.sv
mem_cntl/mem_cntl.sv
source/sram_bank.sv
source/axi_sram_top.sv
verif/tb_axi_sram.sv

/* mem_cntl/arbiter.sv */
`timescale 1ns/1ns
// ------------------
// Write/read burst arbiter
// Alternating priority, grant held until done
// ------------------
module arbiter (
	input  logic clk,
	input  logic resetn,
	input  logic wr_req,
	input  logic rd_req,
	input  logic done,
	output logic wr_granted,
	output logic rd_granted
);

	// Read side wins the next tie
	logic rd_first;
	logic busy;

	assign busy = wr_granted || rd_granted;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_granted <= 1'b0;
			rd_granted <= 1'b0;
			rd_first   <= 1'b0;
		end else if (!busy || done) begin
			if (wr_req && (!rd_req || !rd_first)) begin
				wr_granted <= 1'b1;
				rd_granted <= 1'b0;
				rd_first   <= 1'b1;
			end else if (rd_req) begin
				wr_granted <= 1'b0;
				rd_granted <= 1'b1;
				rd_first   <= 1'b0;
			end else begin
				wr_granted <= 1'b0;
				rd_granted <= 1'b0;
			end
		end
	end

endmodule

/* mem_cntl/mem_cntl.sv */
`timescale 1ns/1ns
// ------------------
// Memory controller
// Burst address sequencing, SRAM drive,
// read return and write response
// ------------------
module mem_cntl (
	input  logic                            clk,
	input  logic                            resetn,
	output logic                            aw_rd_req,
	input  logic                            aw_empty,
	input  logic [axi_pkg::cntl_w-1:0]      aw_dout,
	output logic                            ar_rd_req,
	input  logic                            ar_empty,
	input  logic [axi_pkg::cntl_w-1:0]      ar_dout,
	output logic                            w_rd_req,
	input  logic                            w_empty,
	input  logic [axi_pkg::wdat_w-1:0]      w_dout,
	output logic                            r_wr_req,
	input  logic                            r_full,
	output logic [axi_pkg::rdat_w-1:0]      r_din,
	output logic [mem_pkg::mem_addr_w-1:0]  mem_addr,
	output logic                            mem_ce,
	output logic                            mem_we,
	output logic [mem_pkg::data_w-1:0]      mem_wdata,
	input  logic [mem_pkg::data_w-1:0]      mem_rdata,
	output logic [mem_pkg::strb_w-1:0]      mem_bywe,
	output logic                            bvalid,
	input  logic                            bready,
	output logic [1:0]                      bresp,
	output logic [axi_pkg::id_w-1:0]        bid
);

	logic                        wr_granted;
	logic                        rd_granted;
	logic [1:0]                  state;
	logic [1:0]                  state_nxt;
	logic [axi_pkg::cntl_w-1:0]  cntl_q;
	logic                        wr_burst;

	// Fields of the latched control word
	logic [axi_pkg::addr_w-1:0]  base_addr;
	logic [axi_pkg::len_w-1:0]   len;
	logic [2:0]                  size;
	logic [1:0]                  burst;
	logic [axi_pkg::id_w-1:0]    id;
	logic                        err;

	logic [axi_pkg::len_w-1:0]   beat_cnt;
	logic [axi_pkg::addr_w-1:0]  bytes;
	logic [axi_pkg::addr_w-1:0]  len_ext;
	logic [axi_pkg::addr_w-1:0]  cnt_ext;
	logic [axi_pkg::addr_w-1:0]  offset;
	logic [axi_pkg::addr_w-1:0]  wrap_mask;
	logic [axi_pkg::addr_w-1:0]  beat_addr;

	logic                        wr_ready;
	logic                        rd_ready;
	logic                        beat_go;
	logic                        last_beat;
	logic                        last_pre;
	logic                        done;
	logic                        done_pre;
	logic                        load;

	// Read return tracking
	logic [axi_pkg::len_w-1:0]   issued;
	logic [axi_pkg::len_w-1:0]   served;
	logic                        r_last_q;
	logic [axi_pkg::id_w-1:0]    r_id_q;
	logic                        r_err_q;
	logic [1:0]                  r_resp;
	logic [mem_pkg::data_w-1:0]  r_data;

	arbiter u_arbiter (
		.clk        (clk),
		.resetn     (resetn),
		.wr_req     (!aw_empty),
		.rd_req     (!ar_empty),
		.done       (done_pre),
		.wr_granted (wr_granted),
		.rd_granted (rd_granted)
	);

	assign base_addr = cntl_q[axi_pkg::addr_msb:axi_pkg::addr_lsb];
	assign len       = cntl_q[axi_pkg::len_msb:axi_pkg::len_lsb];
	assign size      = cntl_q[axi_pkg::size_msb:axi_pkg::size_lsb];
	assign burst     = cntl_q[axi_pkg::burst_msb:axi_pkg::burst_lsb];
	assign id        = cntl_q[axi_pkg::id_msb:axi_pkg::id_lsb];
	assign err       = cntl_q[axi_pkg::err_bit];

	// ------------------
	// Beat handshake
	// ------------------
	// Writes wait for W data and a free B slot
	assign wr_ready = !w_empty && !bvalid;
	// At most one read beat waits on the SRAM output
	assign rd_ready = !r_full && ((issued == served) || r_wr_req);
	assign beat_go  = (state != mem_pkg::st_idle) && (wr_burst ? wr_ready : rd_ready);

	assign last_beat = (beat_cnt == len);
	assign last_pre  = (len == '0) ? last_beat : (beat_cnt == len - 1'b1);
	assign done      = beat_go && last_beat;
	// One beat early so the next grant is ready at the final beat
	assign done_pre  = beat_go && last_pre;

	// Single-beat bursts return to idle before the next load
	assign load = (wr_granted || rd_granted) &&
		((state == mem_pkg::st_idle) || ((state == mem_pkg::st_burst) && done));
	assign aw_rd_req = load && wr_granted;
	assign ar_rd_req = load && rd_granted;

	always_comb begin
		state_nxt = state;
		case (state)
			mem_pkg::st_idle: begin
				if (load)
					state_nxt = mem_pkg::st_first;
			end
			mem_pkg::st_first: begin
				if (done)
					state_nxt = mem_pkg::st_idle;
				else if (beat_go)
					state_nxt = mem_pkg::st_burst;
			end
			mem_pkg::st_burst: begin
				if (done)
					state_nxt = load ? mem_pkg::st_first : mem_pkg::st_idle;
			end
			default: state_nxt = mem_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state    <= mem_pkg::st_idle;
			wr_burst <= 1'b0;
			beat_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (load) begin
				wr_burst <= wr_granted;
				beat_cnt <= '0;
			end else if (beat_go) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			cntl_q <= wr_granted ? aw_dout : ar_dout;
	end

	// ------------------
	// Beat address
	// ------------------
	always_comb begin
		bytes       = '0;
		bytes[size] = 1'b1;
	end

	assign len_ext   = {{(axi_pkg::addr_w - axi_pkg::len_w){1'b0}}, len};
	assign cnt_ext   = {{(axi_pkg::addr_w - axi_pkg::len_w){1'b0}}, beat_cnt};
	assign offset    = base_addr + cnt_ext * bytes;
	// Wrap span is beats times bytes
	assign wrap_mask = bytes * (len_ext + 1'b1) - 1'b1;

	always_comb begin
		case (burst)
			axi_pkg::burst_fixed: beat_addr = base_addr;
			axi_pkg::burst_incr:  beat_addr = offset;
			axi_pkg::burst_wrap:  beat_addr = (base_addr & ~wrap_mask) | (offset & wrap_mask);
			default:              beat_addr = offset;
		endcase
	end

	// ------------------
	// SRAM drive
	// ------------------
	assign mem_addr  = beat_addr[axi_pkg::addr_w-1 -: mem_pkg::mem_addr_w];
	assign mem_ce    = beat_go && !err;
	assign mem_we    = wr_burst;
	assign mem_wdata = w_dout[mem_pkg::data_w-1:0];
	assign mem_bywe  = w_dout[mem_pkg::data_w +: mem_pkg::strb_w];
	assign w_rd_req  = beat_go && wr_burst;

	// ------------------
	// Read return
	// ------------------
	assign r_wr_req = (issued != served) && !r_full;
	assign r_resp   = r_err_q ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
	assign r_data   = r_err_q ? '0 : mem_rdata;
	assign r_din    = {r_last_q, r_id_q, r_resp, r_data};

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			issued <= '0;
			served <= '0;
		end else begin
			if (beat_go && !wr_burst)
				issued <= issued + 1'b1;
			if (r_wr_req)
				served <= served + 1'b1;
		end
	end

	// Beat tags held until the SRAM word is pushed
	always_ff @(posedge clk) begin
		if (beat_go && !wr_burst) begin
			r_last_q <= last_beat;
			r_id_q   <= id;
			r_err_q  <= err;
		end
	end

	// ------------------
	// Write response
	// ------------------
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			bvalid <= 1'b0;
		else if (done && wr_burst)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (done && wr_burst) begin
			bid   <= id;
			bresp <= err ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the AXI SRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axi_sram -f files.f \
	-o tb_axi_sram > build.log 2>&1 \
	&& ./obj_dir/tb_axi_sram > sim.log 2>&1 \
	|| { echo "Build or simulation failed"; exit 1; }

grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* source/axi_front.sv */
`timescale 1ns/1ns
// ------------------
// AXI channel front end
// AW/AR packing with error check, W and R FIFOs
// ------------------
module axi_front (
	input  logic                         clk,
	input  logic                         resetn,
	// AW channel
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [axi_pkg::addr_w-1:0]   awaddr,
	input  logic [axi_pkg::len_w-1:0]    awlen,
	input  logic [2:0]                   awsize,
	input  logic [1:0]                   awburst,
	input  logic [axi_pkg::id_w-1:0]     awid,
	// AR channel
	input  logic                         arvalid,
	output logic                         arready,
	input  logic [axi_pkg::addr_w-1:0]   araddr,
	input  logic [axi_pkg::len_w-1:0]    arlen,
	input  logic [2:0]                   arsize,
	input  logic [1:0]                   arburst,
	input  logic [axi_pkg::id_w-1:0]     arid,
	// W channel
	input  logic                         wvalid,
	output logic                         wready,
	input  logic [mem_pkg::data_w-1:0]   wdata,
	input  logic [mem_pkg::strb_w-1:0]   wstrb,
	input  logic                         wlast,
	// R channel
	output logic                         rvalid,
	input  logic                         rready,
	output logic [mem_pkg::data_w-1:0]   rdata,
	output logic [1:0]                   rresp,
	output logic [axi_pkg::id_w-1:0]     rid,
	output logic                         rlast,
	// Controller side
	input  logic                         aw_rd_req,
	output logic                         aw_empty,
	output logic [axi_pkg::cntl_w-1:0]   aw_dout,
	input  logic                         ar_rd_req,
	output logic                         ar_empty,
	output logic [axi_pkg::cntl_w-1:0]   ar_dout,
	input  logic                         w_rd_req,
	output logic                         w_empty,
	output logic [axi_pkg::wdat_w-1:0]   w_dout,
	input  logic                         r_wr_req,
	output logic                         r_full,
	input  logic [axi_pkg::rdat_w-1:0]   r_din
);

	logic                       aw_full;
	logic                       ar_full;
	logic                       w_full;
	logic                       r_empty;
	logic [axi_pkg::cntl_w-1:0] aw_din;
	logic [axi_pkg::cntl_w-1:0] ar_din;
	logic [axi_pkg::wdat_w-1:0] w_din;
	logic [axi_pkg::rdat_w-1:0] r_dout;

	// Size above 32 bits or a WRAP length other than 2/4/8/16 beats
	function automatic logic req_error(
		input logic [2:0]                size,
		input logic [1:0]                burst,
		input logic [axi_pkg::len_w-1:0] len
	);
		logic bad_wrap;
		bad_wrap = (burst == axi_pkg::burst_wrap) && !(len inside {1, 3, 7, 15});
		return (size > 3'd2) || bad_wrap;
	endfunction

	assign awready = !aw_full;
	assign arready = !ar_full;
	assign wready  = !w_full;
	assign rvalid  = !r_empty;

	// ------------------
	// Word packing
	// ------------------
	assign aw_din = {req_error(awsize, awburst, awlen), awid, awburst, awsize, awlen, awaddr};
	assign ar_din = {req_error(arsize, arburst, arlen), arid, arburst, arsize, arlen, araddr};
	// No WID on AXI4, id field stays zero
	assign w_din  = {{axi_pkg::id_w{1'b0}}, wlast, wstrb, wdata};

	assign rdata = r_dout[mem_pkg::data_w-1:0];
	assign rresp = r_dout[mem_pkg::data_w +: 2];
	assign rid   = r_dout[mem_pkg::data_w + 2 +: axi_pkg::id_w];
	assign rlast = r_dout[axi_pkg::rdat_w-1];

	// ------------------
	// Channel FIFOs
	// ------------------
	sync_fifo #(.width(axi_pkg::cntl_w), .depth(mem_pkg::cntl_fifo_depth)) u_aw_fifo (
		.clk(clk), .resetn(resetn),
		.wr_req(awvalid && awready), .din(aw_din),
		.rd_req(aw_rd_req), .dout(aw_dout),
		.empty(aw_empty), .full(aw_full)
	);

	sync_fifo #(.width(axi_pkg::cntl_w), .depth(mem_pkg::cntl_fifo_depth)) u_ar_fifo (
		.clk(clk), .resetn(resetn),
		.wr_req(arvalid && arready), .din(ar_din),
		.rd_req(ar_rd_req), .dout(ar_dout),
		.empty(ar_empty), .full(ar_full)
	);

	sync_fifo #(.width(axi_pkg::wdat_w), .depth(mem_pkg::data_fifo_depth)) u_w_fifo (
		.clk(clk), .resetn(resetn),
		.wr_req(wvalid && wready), .din(w_din),
		.rd_req(w_rd_req), .dout(w_dout),
		.empty(w_empty), .full(w_full)
	);

	sync_fifo #(.width(axi_pkg::rdat_w), .depth(mem_pkg::data_fifo_depth)) u_r_fifo (
		.clk(clk), .resetn(resetn),
		.wr_req(r_wr_req), .din(r_din),
		.rd_req(rvalid && rready), .dout(r_dout),
		.empty(r_empty), .full(r_full)
	);

endmodule

/* source/axi_sram_top.sv */
`timescale 1ns/1ns
// ------------------
// AXI SRAM slave top level
// Front end, memory controller and SRAM bank
// ------------------
module axi_sram_top (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [axi_pkg::addr_w-1:0]  awaddr,
	input  logic [axi_pkg::len_w-1:0]   awlen,
	input  logic [2:0]                  awsize,
	input  logic [1:0]                  awburst,
	input  logic [axi_pkg::id_w-1:0]    awid,
	input  logic                        arvalid,
	output logic                        arready,
	input  logic [axi_pkg::addr_w-1:0]  araddr,
	input  logic [axi_pkg::len_w-1:0]   arlen,
	input  logic [2:0]                  arsize,
	input  logic [1:0]                  arburst,
	input  logic [axi_pkg::id_w-1:0]    arid,
	input  logic                        wvalid,
	output logic                        wready,
	input  logic [mem_pkg::data_w-1:0]  wdata,
	input  logic [mem_pkg::strb_w-1:0]  wstrb,
	input  logic                        wlast,
	output logic                        rvalid,
	input  logic                        rready,
	output logic [mem_pkg::data_w-1:0]  rdata,
	output logic [1:0]                  rresp,
	output logic [axi_pkg::id_w-1:0]    rid,
	output logic                        rlast,
	output logic                        bvalid,
	input  logic                        bready,
	output logic [1:0]                  bresp,
	output logic [axi_pkg::id_w-1:0]    bid
);

	// FIFO traffic between front end and controller
	logic                           aw_rd_req;
	logic                           aw_empty;
	logic [axi_pkg::cntl_w-1:0]     aw_dout;
	logic                           ar_rd_req;
	logic                           ar_empty;
	logic [axi_pkg::cntl_w-1:0]     ar_dout;
	logic                           w_rd_req;
	logic                           w_empty;
	logic [axi_pkg::wdat_w-1:0]     w_dout;
	logic                           r_wr_req;
	logic                           r_full;
	logic [axi_pkg::rdat_w-1:0]     r_din;

	// SRAM port
	logic [mem_pkg::mem_addr_w-1:0] mem_addr;
	logic                           mem_ce;
	logic                           mem_we;
	logic [mem_pkg::data_w-1:0]     mem_wdata;
	logic [mem_pkg::data_w-1:0]     mem_rdata;
	logic [mem_pkg::strb_w-1:0]     mem_bywe;

	axi_front u_axi_front (
		.clk(clk), .resetn(resetn),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awlen(awlen),
		.awsize(awsize), .awburst(awburst), .awid(awid),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
		.arsize(arsize), .arburst(arburst), .arid(arid),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.rid(rid), .rlast(rlast),
		.aw_rd_req(aw_rd_req), .aw_empty(aw_empty), .aw_dout(aw_dout),
		.ar_rd_req(ar_rd_req), .ar_empty(ar_empty), .ar_dout(ar_dout),
		.w_rd_req(w_rd_req), .w_empty(w_empty), .w_dout(w_dout),
		.r_wr_req(r_wr_req), .r_full(r_full), .r_din(r_din)
	);

	mem_cntl u_mem_cntl (
		.clk(clk), .resetn(resetn),
		.aw_rd_req(aw_rd_req), .aw_empty(aw_empty), .aw_dout(aw_dout),
		.ar_rd_req(ar_rd_req), .ar_empty(ar_empty), .ar_dout(ar_dout),
		.w_rd_req(w_rd_req), .w_empty(w_empty), .w_dout(w_dout),
		.r_wr_req(r_wr_req), .r_full(r_full), .r_din(r_din),
		.mem_addr(mem_addr), .mem_ce(mem_ce), .mem_we(mem_we),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_bywe(mem_bywe),
		.bvalid(bvalid), .bready(bready), .bresp(bresp), .bid(bid)
	);

	sram_bank u_sram_bank (
		.clk   (clk),
		.ce    (mem_ce),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.bywe  (mem_bywe),
		.rdata (mem_rdata)
	);

endmodule

/* source/sram_bank.sv */
`timescale 1ns/1ns
// ------------------
// 16K x 32 single-port SRAM
// Byte write enables, registered read
// ------------------
module sram_bank (
	input  logic                           clk,
	input  logic                           ce,
	input  logic                           we,
	input  logic [mem_pkg::mem_addr_w-1:0] addr,
	input  logic [mem_pkg::data_w-1:0]     wdata,
	input  logic [mem_pkg::strb_w-1:0]     bywe,
	output logic [mem_pkg::data_w-1:0]     rdata
);

	logic [mem_pkg::data_w-1:0] mem [mem_pkg::mem_words];

	// Read output holds until the next enabled read
	always_ff @(posedge clk) begin
		if (ce) begin
			if (we) begin
				for (int i = 0; i < mem_pkg::strb_w; i++) begin
					if (bywe[i])
						mem[addr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ns
// ------------------
// Synchronous FIFO, show-ahead output
// Power-of-two depth
// ------------------
module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 4
) (
	input  logic             clk,
	input  logic             resetn,
	input  logic             wr_req,
	input  logic [width-1:0] din,
	input  logic             rd_req,
	output logic [width-1:0] dout,
	output logic             empty,
	output logic             full
);

	localparam int ptr_w = $clog2(depth);

	logic [width-1:0] buffer [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_req && !full;
	assign do_rd = rd_req && !empty;
	assign empty = (count == '0);
	assign full  = (count == (ptr_w + 1)'(depth));
	// Head entry always on the output
	assign dout  = buffer[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			buffer[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* verif/tb_axi_sram.sv */
`timescale 1ns/1ns
// --------------------
// AXI SRAM slave testbench
// Clock, reset, burst stimulus and byte model
// R and B compare processes
// --------------------
module tb_axi_sram;

	localparam int tmo_cycles = 2000;

	logic                           clk;
	logic                           resetn;
	logic                           awvalid;
	logic                           awready;
	logic [axi_pkg::addr_w-1:0]     awaddr;
	logic [axi_pkg::len_w-1:0]      awlen;
	logic [2:0]                     awsize;
	logic [1:0]                     awburst;
	logic [axi_pkg::id_w-1:0]       awid;
	logic                           arvalid;
	logic                           arready;
	logic [axi_pkg::addr_w-1:0]     araddr;
	logic [axi_pkg::len_w-1:0]      arlen;
	logic [2:0]                     arsize;
	logic [1:0]                     arburst;
	logic [axi_pkg::id_w-1:0]       arid;
	logic                           wvalid;
	logic                           wready;
	logic [mem_pkg::data_w-1:0]     wdata;
	logic [mem_pkg::strb_w-1:0]     wstrb;
	logic                           wlast;
	logic                           rvalid;
	logic                           rready;
	logic [mem_pkg::data_w-1:0]     rdata;
	logic [1:0]                     rresp;
	logic [axi_pkg::id_w-1:0]       rid;
	logic                           rlast;
	logic                           bvalid;
	logic                           bready;
	logic [1:0]                     bresp;
	logic [axi_pkg::id_w-1:0]       bid;

	// Byte image of the SRAM
	logic [7:0] model [65536];

	// Expected R beats and B responses in channel order
	logic [mem_pkg::data_w-1:0]     exp_rdata [$];
	logic [1:0]                     exp_rresp [$];
	logic [axi_pkg::id_w-1:0]       exp_rid [$];
	logic                           exp_rlast [$];
	logic [1:0]                     exp_bresp [$];
	logic [axi_pkg::id_w-1:0]       exp_bid [$];

	int   r_errors;
	int   b_errors;
	int   other_errors;
	logic random_ready;
	event abort_ev;

	axi_sram_top u_axi_sram_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------
	// Reference model
	// --------------------
	// Size above 32 bits, or WRAP not 2/4/8/16 beats
	function automatic logic burst_bad(input logic [2:0] size, input logic [1:0] burst,
		input logic [axi_pkg::len_w-1:0] len);
		logic wrap_ok;
		wrap_ok = (len == 4'd1) || (len == 4'd3) || (len == 4'd7) || (len == 4'd15);
		return (size > 3'd2) || ((burst == axi_pkg::burst_wrap) && !wrap_ok);
	endfunction

	// Wrap boundary sits at a multiple of beats times bytes
	function automatic logic [axi_pkg::addr_w-1:0] beat_addr(
		input logic [axi_pkg::addr_w-1:0] addr, input logic [axi_pkg::len_w-1:0] len,
		input logic [2:0] size, input logic [1:0] burst, input int beat);
		int bytes;
		int total;
		int lower;
		int a;
		bytes = 1 << size;
		total = bytes * (int'(len) + 1);
		lower = (int'(addr) / total) * total;
		a = int'(addr) + beat * bytes;
		if (burst == axi_pkg::burst_fixed)
			a = int'(addr);
		else if ((burst == axi_pkg::burst_wrap) && (a >= lower + total))
			a = a - total;
		return a[axi_pkg::addr_w-1:0];
	endfunction

	// Expected {resp, data} of one read beat
	function automatic logic [mem_pkg::data_w+1:0] ref_rbeat(
		input logic [axi_pkg::addr_w-1:0] addr, input logic [axi_pkg::len_w-1:0] len,
		input logic [2:0] size, input logic [1:0] burst, input int beat);
		logic [axi_pkg::addr_w-1:0] a;
		logic [mem_pkg::data_w-1:0] data;
		if (burst_bad(size, burst, len))
			return {axi_pkg::resp_slverr, 32'h0};
		a = beat_addr(addr, len, size, burst, beat) & 16'hfffc;
		data = {model[a + 3], model[a + 2], model[a + 1], model[a]};
		return {axi_pkg::resp_okay, data};
	endfunction

	task automatic model_write(input logic [axi_pkg::addr_w-1:0] addr,
		input logic [mem_pkg::data_w-1:0] data, input logic [mem_pkg::strb_w-1:0] strb);
		logic [axi_pkg::addr_w-1:0] a;
		a = addr & 16'hfffc;
		for (int i = 0; i < mem_pkg::strb_w; i++) begin
			if (strb[i])
				model[a + i] = data[8*i +: 8];
		end
	endtask

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_rbeat(input logic [mem_pkg::data_w-1:0] data, input logic [1:0] resp,
		input logic [axi_pkg::id_w-1:0] id, input logic last,
		input logic [mem_pkg::data_w-1:0] e_data, input logic [1:0] e_resp,
		input logic [axi_pkg::id_w-1:0] e_id, input logic e_last);
		if (resp !== e_resp) begin
			$display("ERROR rresp got %h expected %h", resp, e_resp);
			r_errors++;
		end
		if (id !== e_id) begin
			$display("ERROR rid got %h expected %h", id, e_id);
			r_errors++;
		end
		if (last !== e_last) begin
			$display("ERROR rlast got %h expected %h", last, e_last);
			r_errors++;
		end
		// Error bursts carry no data
		if ((e_resp == axi_pkg::resp_okay) && (data !== e_data)) begin
			$display("ERROR rdata got %h expected %h", data, e_data);
			r_errors++;
		end
	endtask

	task automatic check_bresp(input logic [1:0] resp, input logic [axi_pkg::id_w-1:0] id,
		input logic [1:0] e_resp, input logic [axi_pkg::id_w-1:0] e_id);
		if (resp !== e_resp) begin
			$display("ERROR bresp got %h expected %h", resp, e_resp);
			b_errors++;
		end
		if (id !== e_id) begin
			$display("ERROR bid got %h expected %h", id, e_id);
			b_errors++;
		end
	endtask

	// R channel, one beat moves at the rising edge after a sample here
	initial begin
		rready = 1'b0;
		forever begin
			@(negedge clk);
			rready = random_ready ? 1'($urandom % 2) : 1'b1;
			if (rvalid && rready) begin
				if (exp_rdata.size() == 0) begin
					$display("Unexpected R beat with id %h", rid);
					other_errors++;
				end else begin
					check_rbeat(rdata, rresp, rid, rlast, exp_rdata.pop_front(),
						exp_rresp.pop_front(), exp_rid.pop_front(), exp_rlast.pop_front());
				end
			end
		end
	end

	// B channel
	initial begin
		bready = 1'b0;
		forever begin
			@(negedge clk);
			bready = random_ready ? 1'($urandom % 2) : 1'b1;
			if (bvalid && bready) begin
				if (exp_bid.size() == 0) begin
					$display("Unexpected write response with id %h", bid);
					other_errors++;
				end else begin
					check_bresp(bresp, bid, exp_bresp.pop_front(), exp_bid.pop_front());
				end
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	function automatic logic ready_of(input int chan);
		case (chan)
			0:       return awready;
			1:       return arready;
			default: return wready;
		endcase
	endfunction

	// Transfer happens at the rising edge after ready is seen here
	task automatic wait_ready(input int chan, input string what);
		int t;
		t = 0;
		while (!ready_of(chan) && (t < tmo_cycles)) begin
			@(negedge clk);
			t++;
		end
		if (!ready_of(chan)) begin
			$display("Timeout: %s stayed low", what);
			other_errors++;
			-> abort_ev;
		end
		@(negedge clk);
	endtask

	task automatic send_write(input logic [axi_pkg::addr_w-1:0] addr,
		input logic [axi_pkg::len_w-1:0] len, input logic [2:0] size, input logic [1:0] burst,
		input logic [axi_pkg::id_w-1:0] id, input logic rand_strb);
		logic bad;
		bad = burst_bad(size, burst, len);
		exp_bresp.push_back(bad ? axi_pkg::resp_slverr : axi_pkg::resp_okay);
		exp_bid.push_back(id);
		awaddr = addr;
		awlen = len;
		awsize = size;
		awburst = burst;
		awid = id;
		awvalid = 1'b1;
		wait_ready(0, "awready");
		awvalid = 1'b0;
		for (int b = 0; b <= int'(len); b++) begin
			wdata = $urandom;
			wstrb = rand_strb ? 4'($urandom) : 4'hf;
			wlast = (b == int'(len));
			wvalid = 1'b1;
			if (!bad)
				model_write(beat_addr(addr, len, size, burst, b), wdata, wstrb);
			wait_ready(2, "wready");
		end
		wvalid = 1'b0;
		wlast = 1'b0;
	endtask

	task automatic send_read(input logic [axi_pkg::addr_w-1:0] addr,
		input logic [axi_pkg::len_w-1:0] len, input logic [2:0] size, input logic [1:0] burst,
		input logic [axi_pkg::id_w-1:0] id);
		logic [mem_pkg::data_w+1:0] e;
		for (int b = 0; b <= int'(len); b++) begin
			e = ref_rbeat(addr, len, size, burst, b);
			exp_rdata.push_back(e[mem_pkg::data_w-1:0]);
			exp_rresp.push_back(e[mem_pkg::data_w +: 2]);
			exp_rid.push_back(id);
			exp_rlast.push_back(b == int'(len));
		end
		araddr = addr;
		arlen = len;
		arsize = size;
		arburst = burst;
		arid = id;
		arvalid = 1'b1;
		wait_ready(1, "arready");
		arvalid = 1'b0;
	endtask

	// Wait for every expected beat and response
	task automatic drain(input string what);
		int t;
		t = 0;
		while (((exp_rdata.size() != 0) || (exp_bid.size() != 0)) && (t < tmo_cycles)) begin
			@(negedge clk);
			t++;
		end
		if ((exp_rdata.size() != 0) || (exp_bid.size() != 0)) begin
			$display("Timeout: responses still missing after %s", what);
			other_errors++;
			-> abort_ev;
		end
	endtask

	task automatic finish_run();
		$display("Errors: R %0d, B %0d, other %0d", r_errors, b_errors, other_errors);
		if (r_errors + b_errors + other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	initial begin
		@(abort_ev);
		finish_run();
	end

	initial begin
		void'($urandom(32'h93de));
		r_errors = 0;
		b_errors = 0;
		other_errors = 0;
		random_ready = 1'b0;
		resetn = 1'b0;
		{awvalid, awaddr, awlen, awsize, awburst, awid} = '0;
		{arvalid, araddr, arlen, arsize, arburst, arid} = '0;
		{wvalid, wdata, wstrb, wlast} = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		@(negedge clk);

		// Known contents in 0x0000 to 0x07ff
		for (int i = 0; i < 32; i++)
			send_write(16'(i * 64), 4'd15, 3'd2, axi_pkg::burst_incr, 4'(i), 1'b0);
		drain("fill");

		// INCR with random strobes, read back merged
		for (int i = 0; i < 6; i++)
			send_write(16'(16'h0100 + i * 64), 4'($urandom), 3'd2, axi_pkg::burst_incr, 4'(i), 1'b1);
		drain("INCR writes");
		for (int i = 0; i < 6; i++)
			send_read(16'(16'h0100 + i * 64), 4'd15, 3'd2, axi_pkg::burst_incr, 4'(i + 8));
		drain("INCR reads");

		// WRAP starting mid-boundary
		for (int k = 0; k < 4; k++) begin
			send_write(16'(16'h0400 + k * 64 + ((2 << k) * 4) / 2), 4'((2 << k) - 1), 3'd2,
				axi_pkg::burst_wrap, 4'(k), 1'b1);
			drain("WRAP write");
			send_read(16'(16'h0400 + k * 64 + ((2 << k) * 4) / 2), 4'((2 << k) - 1), 3'd2,
				axi_pkg::burst_wrap, 4'(k + 4));
			send_read(16'(16'h0400 + k * 64), 4'((2 << k) - 1), 3'd2, axi_pkg::burst_incr, 4'(k));
			drain("WRAP reads");
		end

		// FIXED, last beat wins
		send_write(16'h0500, 4'd7, 3'd2, axi_pkg::burst_fixed, 4'd3, 1'b0);
		drain("FIXED write");
		send_read(16'h0500, 4'd3, 3'd2, axi_pkg::burst_fixed, 4'd5);
		drain("FIXED read");

		// Error bursts, memory left as it was
		send_write(16'h0600, 4'd3, 3'd3, axi_pkg::burst_incr, 4'd9, 1'b0);
		send_write(16'h0640, 4'd2, 3'd2, axi_pkg::burst_wrap, 4'd10, 1'b0);
		drain("error writes");
		send_read(16'h0600, 4'd1, 3'd3, axi_pkg::burst_incr, 4'd11);
		send_read(16'h0640, 4'd4, 3'd2, axi_pkg::burst_wrap, 4'd12);
		send_read(16'h0600, 4'd15, 3'd2, axi_pkg::burst_incr, 4'd13);
		send_read(16'h0640, 4'd3, 3'd2, axi_pkg::burst_incr, 4'd14);
		drain("error reads");

		// Random back-pressure on R and B
		random_ready = 1'b1;
		for (int i = 0; i < 8; i++)
			send_write(16'(i * 64), 4'($urandom), 3'd2, axi_pkg::burst_incr, 4'(i), 1'b1);
		for (int i = 0; i < 8; i++)
			send_read(16'(i * 64), 4'($urandom), 3'd2, axi_pkg::burst_incr, 4'(15 - i));
		drain("back-pressure traffic");

		// Writes and reads overlapping on disjoint regions
		fork
			for (int i = 0; i < 8; i++)
				send_write(16'(16'h0200 + i * 64), 4'($urandom), 3'd2, axi_pkg::burst_incr,
					4'(i), 1'b1);
			for (int i = 0; i < 8; i++)
				send_read(16'(i * 64), 4'd15, 3'd2, axi_pkg::burst_incr, 4'(i + 8));
		join
		drain("overlapped traffic");
		for (int i = 0; i < 8; i++)
			send_read(16'(16'h0200 + i * 64), 4'd15, 3'd2, axi_pkg::burst_incr, 4'(i));
		drain("overlap read-back");
		random_ready = 1'b0;

		finish_run();
	end

endmodule
